// File: mipsStim.txt
# P <instruction word, hex>: next program word, from index 0 up
# S <byte address, hex> <data, hex>: next expected store, in program order
P 20010005
P 20020007
P 00221820
P AC030000
P 00612022
P 00642824
P 00A23025
P 0083382A
P 2008FFFD
P 0101482A
P 00225022
P AC050004
P AC060008
P AC07000C
P AC090010
P AC0A0014
# load then dependent add and store
P 8C0B0000
P 01646020
P AC0C0018
# beq not taken, beq taken, bne taken, jump
P 10220003
P 200D0064
P 10C40002
P AC010024
P AC020028
P AC0D001C
P 14220001
P AC01002C
P 0800001E
P AC020030
P AC010034
P AC080020
P FC000000
S 00000000 0000000C
S 00000004 00000004
S 00000008 00000007
S 0000000C 00000001
S 00000010 00000001
S 00000014 FFFFFFFE
S 00000018 00000013
S 0000001C 00000064
S 00000020 FFFFFFFD

// File: all.f
isaPkg.sv
pipePkg.sv
pipeIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
mipsPipeline.sv
tbMipsPipeline.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbMipsPipeline -f all.f -o simMipsPipeline &&
./obj_dir/simMipsPipeline | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tbMipsPipeline.sv
// ##########################################################
// tbMipsPipeline
// loads the program from the stimulus file through the imem
// load port, runs the core and checks each store and fin
// ##########################################################
module tbMipsPipeline;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;
    localparam int FIN_TIMEOUT  = 1000;
    localparam int DRAIN_CYCLES = 20;

    logic              clk;
    logic              rstN;
    logic              run;
    logic              imemWrEn;
    pipePkg::imemIdx_t imemWrAddr;
    isaPkg::word_t     imemWrData;
    logic              storeEn;
    isaPkg::word_t     storeAddr;
    isaPkg::word_t     storeData;
    logic              fin;

    isaPkg::word_t prog [$];
    isaPkg::word_t expAddr [$];
    isaPkg::word_t expData [$];
    int            storeCount;

    mipsPipeline DUT (
        .clk(clk),
        .rstN(rstN),
        .run(run),
        .imemWrEn(imemWrEn),
        .imemWrAddr(imemWrAddr),
        .imemWrData(imemWrData),
        .storeEn(storeEn),
        .storeAddr(storeAddr),
        .storeData(storeData),
        .fin(fin)
    );

    always #2 clk = ~clk;

    task automatic failRun(input string why);
        $display("ERROR at %0d ns: %s", $time, why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input isaPkg::word_t got,
                              input isaPkg::word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            failRun($sformatf("%s differs from its expected value", name));
        end
    endtask

    // storeEn and fin are low in reset and while run is low
    task automatic expectIdle();
        checkValue("storeEn", {31'd0, storeEn}, 32'd0);
        checkValue("fin", {31'd0, fin}, 32'd0);
    endtask

    // P lines hold program words, S lines the expected stores in order
    task automatic readStim();
        int            fd;
        int            n;
        string         line;
        byte           tag;
        isaPkg::word_t a;
        isaPkg::word_t b;
        fd = $fopen("mipsStim.txt", "r");
        if (fd == 0)
            failRun("cannot open mipsStim.txt for reading");
        while ($fgets(line, fd) != 0) begin
            tag = line.getc(0);
            if (tag == "P") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h", a);
                if (n != 1)
                    failRun("malformed program line in mipsStim.txt");
                else
                    prog.push_back(a);
            end else if (tag == "S") begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                if (n != 2) begin
                    failRun("malformed store line in mipsStim.txt");
                end else begin
                    expAddr.push_back(a);
                    expData.push_back(b);
                end
            end
        end
        $fclose(fd);
        if (prog.size() == 0 || prog.size() > pipePkg::IMEM_DEPTH || expAddr.size() == 0)
            failRun("mipsStim.txt holds no usable program or no expected stores");
    endtask

    // the whole imem is written and words past the program become NOPs
    task automatic loadProgram();
        for (int i = 0; i < pipePkg::IMEM_DEPTH; i++) begin
            @(negedge clk);
            expectIdle();
            imemWrEn   = 1'b1;
            imemWrAddr = pipePkg::imemIdx_t'(i);
            imemWrData = (i < prog.size()) ? prog[i] : isaPkg::NOP_WORD;
        end
    endtask

    task automatic waitForFin();
        int cycles;
        cycles = 0;
        while (fin !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > FIN_TIMEOUT)
                failRun("fin did not rise before the timeout");
        end
    endtask

    // a store occupies EX/MEM for one cycle, so each is seen once
    always @(posedge clk) begin
        if (rstN && storeEn) begin
            if (storeCount >= expAddr.size()) begin
                failRun($sformatf("unexpected store of %h to address %h", storeData,
                                  storeAddr));
            end else begin
                checkValue("storeAddr", storeAddr, expAddr[storeCount]);
                checkValue("storeData", storeData, expData[storeCount]);
                storeCount++;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        run        = 1'b0;
        imemWrEn   = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        storeCount = 0;
        readStim();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            expectIdle();
        end
        rstN = 1'b1;
        loadProgram();
        @(negedge clk);
        imemWrEn = 1'b0;
        run      = 1'b1;

        waitForFin();
        // the last store comes before the finish instruction
        checkValue("storeCount", storeCount, expAddr.size());

        // fin is sticky and nothing is stored after it
        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            checkValue("fin", {31'd0, fin}, 32'd1);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: mipsPipeline.sv
// ##########################################################
// mipsPipeline
// five-stage MIPS subset core: fetch, decode, execute,
// memory and writeback, with forwarding and load-use stall
// ##########################################################
module mipsPipeline (
    input  logic              clk,
    input  logic              rstN,
    input  logic              run,
    input  logic              imemWrEn,
    input  pipePkg::imemIdx_t imemWrAddr,
    input  isaPkg::word_t     imemWrData,
    output logic              storeEn,
    output isaPkg::word_t     storeAddr,
    output isaPkg::word_t     storeData,
    output logic              fin
);
    isaPkg::word_t    ifIdInstr;
    isaPkg::word_t    ifIdPcNext;
    isaPkg::regAddr_t ifIdRs;
    isaPkg::regAddr_t ifIdRt;
    logic             stall;
    logic             pcLoad;
    isaPkg::word_t    pcTarget;
    pipePkg::fwdSel_t fwdA;
    pipePkg::fwdSel_t fwdB;
    logic             wbRegWr;
    isaPkg::regAddr_t wbDst;
    isaPkg::word_t    wbData;

    idExIf  idEx ();
    exMemIf exMem ();

    fetchStage uFetch (.clk(clk), .rstN(rstN), .run(run), .imemWrEn(imemWrEn),
        .imemWrAddr(imemWrAddr), .imemWrData(imemWrData), .stall(stall),
        .pcLoad(pcLoad), .pcTarget(pcTarget), .ifIdInstr(ifIdInstr),
        .ifIdPcNext(ifIdPcNext));

    decodeStage uDecode (.clk(clk), .rstN(rstN), .ifIdInstr(ifIdInstr),
        .ifIdPcNext(ifIdPcNext), .stall(stall), .pcLoad(pcLoad), .wbRegWr(wbRegWr),
        .wbDst(wbDst), .wbData(wbData), .ifIdRs(ifIdRs), .ifIdRt(ifIdRt),
        .idEx(idEx.producer));

    executeStage uExecute (.clk(clk), .rstN(rstN), .pcLoad(pcLoad), .fwdA(fwdA),
        .fwdB(fwdB), .wbData(wbData), .idEx(idEx.consumer), .exMem(exMem.producer));

    memoryStage uMemory (.clk(clk), .rstN(rstN), .exMem(exMem.consumer),
        .pcLoad(pcLoad), .pcTarget(pcTarget), .storeEn(storeEn),
        .storeAddr(storeAddr), .storeData(storeData), .wbRegWr(wbRegWr),
        .wbDst(wbDst), .wbData(wbData), .fin(fin));

    hazardUnit uHazard (.ifIdRs(ifIdRs), .ifIdRt(ifIdRt), .wbRegWr(wbRegWr),
        .wbDst(wbDst), .idEx(idEx.monitor), .exMem(exMem.monitor), .fwdA(fwdA),
        .fwdB(fwdB), .stall(stall));

endmodule

// File: hazardUnit.sv
// ##########################################################
// hazardUnit
// forward selects for the execute operands and load-use
// stall detection against the instruction in decode
// ##########################################################
module hazardUnit (
    input  isaPkg::regAddr_t ifIdRs,
    input  isaPkg::regAddr_t ifIdRt,
    input  logic             wbRegWr,
    input  isaPkg::regAddr_t wbDst,
    idExIf.monitor           idEx,
    exMemIf.monitor          exMem,
    output pipePkg::fwdSel_t fwdA,
    output pipePkg::fwdSel_t fwdB,
    output logic             stall
);

    // newest result first; register 0 is never forwarded
    function automatic pipePkg::fwdSel_t pickFwd(isaPkg::regAddr_t src,
                                                 logic exWr, isaPkg::regAddr_t exDst,
                                                 logic wbWr, isaPkg::regAddr_t wbD);
        if (src == '0)
            return pipePkg::FWD_NONE;
        if (exWr && exDst == src)
            return pipePkg::FWD_EXMEM;
        if (wbWr && wbD == src)
            return pipePkg::FWD_MEMWB;
        return pipePkg::FWD_NONE;
    endfunction

    always_comb begin
        fwdA = pickFwd(idEx.rs, exMem.regWr, exMem.dst, wbRegWr, wbDst);
        fwdB = pickFwd(idEx.rt, exMem.regWr, exMem.dst, wbRegWr, wbDst);
    end

    // a load in execute feeding the instruction in decode
    assign stall = idEx.memRd && idEx.rt != '0 && (idEx.rt == ifIdRs || idEx.rt == ifIdRt);

endmodule

// File: memoryStage.sv
// ##########################################################
// memoryStage
// branch and jump decision, data memory with store port,
// MEM/WB register, writeback select and the finish flag
// ##########################################################
module memoryStage (
    input  logic             clk,
    input  logic             rstN,
    exMemIf.consumer         exMem,
    output logic             pcLoad,
    output isaPkg::word_t    pcTarget,
    output logic             storeEn,
    output isaPkg::word_t    storeAddr,
    output isaPkg::word_t    storeData,
    output logic             wbRegWr,
    output isaPkg::regAddr_t wbDst,
    output isaPkg::word_t    wbData,
    output logic             fin
);
    pipePkg::dmemIdx_t dIdx;
    isaPkg::word_t     rdData;
    isaPkg::word_t     dmem [pipePkg::DMEM_DEPTH];
    logic              mwMemToReg;
    logic              mwFin;
    isaPkg::word_t     mwLoad;
    isaPkg::word_t     mwAlu;

    // zero comes from rs - rt
    assign pcLoad   = exMem.jump || (exMem.beq && exMem.zero) || (exMem.bne && !exMem.zero);
    assign pcTarget = exMem.jump ? exMem.jmpTarget : exMem.brTarget;

    assign storeEn   = exMem.memWr;
    assign storeAddr = exMem.aluResult;
    assign storeData = exMem.storeData;

    assign dIdx   = exMem.aluResult[9:2];
    assign rdData = exMem.memRd ? dmem[dIdx] : '0;

    always_ff @(posedge clk) begin
        if (exMem.memWr)
            dmem[dIdx] <= exMem.storeData;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbRegWr    <= 1'b0;
            mwMemToReg <= 1'b0;
            mwFin      <= 1'b0;
            fin        <= 1'b0;
        end else begin
            wbRegWr    <= exMem.regWr;
            mwMemToReg <= exMem.memToReg;
            mwFin      <= exMem.isFin;
            // sticky until reset
            fin        <= fin || mwFin;
        end
    end

    always_ff @(posedge clk) begin
        wbDst  <= exMem.dst;
        mwLoad <= rdData;
        mwAlu  <= exMem.aluResult;
    end

    assign wbData = mwMemToReg ? mwLoad : mwAlu;

    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        storeEn |-> storeAddr[1:0] == 2'b00);

endmodule

// File: executeStage.sv
// ##########################################################
// executeStage
// operand forwarding, ALU control and ALU, destination
// select and the EX/MEM register
// ##########################################################
module executeStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             pcLoad,
    input  pipePkg::fwdSel_t fwdA,
    input  pipePkg::fwdSel_t fwdB,
    input  isaPkg::word_t    wbData,
    idExIf.consumer          idEx,
    exMemIf.producer         exMem
);
    isaPkg::word_t  opA;
    isaPkg::word_t  rtFwd;
    isaPkg::word_t  opB;
    isaPkg::word_t  result;
    isaPkg::aluOp_t aluCtl;

    function automatic isaPkg::word_t fwdMux(pipePkg::fwdSel_t sel, isaPkg::word_t regVal,
                                             isaPkg::word_t exVal, isaPkg::word_t wbVal);
        case (sel)
            pipePkg::FWD_EXMEM: return exVal;
            pipePkg::FWD_MEMWB: return wbVal;
            default:            return regVal;
        endcase
    endfunction

    always_comb begin
        opA   = fwdMux(fwdA, idEx.rsVal, exMem.aluResult, wbData);
        rtFwd = fwdMux(fwdB, idEx.rtVal, exMem.aluResult, wbData);
        opB   = idEx.aluSrc ? idEx.imm : rtFwd;
    end

    // R-type (regDst set) takes its operation from funct
    always_comb begin
        aluCtl = idEx.aluOp;
        if (idEx.regDst) begin
            case (idEx.funct)
                isaPkg::FN_SUB: aluCtl = isaPkg::ALU_SUB;
                isaPkg::FN_AND: aluCtl = isaPkg::ALU_AND;
                isaPkg::FN_OR:  aluCtl = isaPkg::ALU_OR;
                isaPkg::FN_SLT: aluCtl = isaPkg::ALU_SLT;
                default:        aluCtl = isaPkg::ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (aluCtl)
            isaPkg::ALU_SUB: result = opA - opB;
            isaPkg::ALU_AND: result = opA & opB;
            isaPkg::ALU_OR:  result = opA | opB;
            isaPkg::ALU_SLT: result = {31'd0, $signed(opA) < $signed(opB)};
            default:         result = opA + opB;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            {exMem.regWr, exMem.memRd, exMem.memWr, exMem.memToReg} <= '0;
            {exMem.beq, exMem.bne, exMem.jump, exMem.isFin} <= '0;
        end else begin
            exMem.regWr    <= idEx.regWr && !pcLoad;
            exMem.memRd    <= idEx.memRd && !pcLoad;
            exMem.memWr    <= idEx.memWr && !pcLoad;
            exMem.memToReg <= idEx.memToReg && !pcLoad;
            exMem.beq      <= idEx.beq && !pcLoad;
            exMem.bne      <= idEx.bne && !pcLoad;
            exMem.jump     <= idEx.jump && !pcLoad;
            exMem.isFin    <= idEx.isFin && !pcLoad;
        end
    end

    always_ff @(posedge clk) begin
        exMem.zero      <= (result == '0);
        exMem.aluResult <= result;
        exMem.storeData <= rtFwd;
        exMem.dst       <= idEx.regDst ? idEx.rd : idEx.rt;
        exMem.brTarget  <= idEx.brTarget;
        exMem.jmpTarget <= idEx.jmpTarget;
    end

    // code 3 would quietly select the register value
    fwdCodeValid: assert property (@(posedge clk) disable iff (!rstN)
        fwdA != 2'd3 && fwdB != 2'd3);

endmodule

// File: decodeStage.sv
// ##########################################################
// decodeStage
// control decode, register file with writeback bypass,
// immediate extension, branch and jump targets, ID/EX
// ##########################################################
module decodeStage (
    input  logic             clk,
    input  logic             rstN,
    input  isaPkg::word_t    ifIdInstr,
    input  isaPkg::word_t    ifIdPcNext,
    input  logic             stall,
    input  logic             pcLoad,
    input  logic             wbRegWr,
    input  isaPkg::regAddr_t wbDst,
    input  isaPkg::word_t    wbData,
    output isaPkg::regAddr_t ifIdRs,
    output isaPkg::regAddr_t ifIdRt,
    idExIf.producer          idEx
);
    isaPkg::opcode_t  opcode;
    isaPkg::imm_t     imm;
    isaPkg::word_t    immExt;
    isaPkg::word_t    rsVal;
    isaPkg::word_t    rtVal;
    isaPkg::word_t    regs [32];
    isaPkg::aluOp_t   cAluOp;
    logic cRegWr, cMemRd, cMemWr, cMemToReg, cBeq, cBne, cJump, cAluSrc, cRegDst, cIsFin;
    logic bubble;

    assign opcode = ifIdInstr[31:26];
    assign ifIdRs = ifIdInstr[25:21];
    assign ifIdRt = ifIdInstr[20:16];
    assign imm    = ifIdInstr[15:0];
    assign immExt = {{16{imm[15]}}, imm};
    assign bubble = stall || pcLoad;

    always_comb begin
        {cRegWr, cMemRd, cMemWr, cMemToReg, cBeq} = '0;
        {cBne, cJump, cAluSrc, cRegDst, cIsFin} = '0;
        cAluOp = isaPkg::ALU_ADD;
        case (opcode)
            isaPkg::OP_RTYPE: begin
                cRegWr  = 1'b1;
                cRegDst = 1'b1;
            end
            isaPkg::OP_ADDI: begin
                cRegWr  = 1'b1;
                cAluSrc = 1'b1;
            end
            isaPkg::OP_LW: begin
                cRegWr    = 1'b1;
                cMemRd    = 1'b1;
                cMemToReg = 1'b1;
                cAluSrc   = 1'b1;
            end
            isaPkg::OP_SW: begin
                cMemWr  = 1'b1;
                cAluSrc = 1'b1;
            end
            isaPkg::OP_BEQ: begin
                cBeq   = 1'b1;
                cAluOp = isaPkg::ALU_SUB;
            end
            isaPkg::OP_BNE: begin
                cBne   = 1'b1;
                cAluOp = isaPkg::ALU_SUB;
            end
            isaPkg::OP_J:   cJump  = 1'b1;
            isaPkg::OP_FIN: cIsFin = 1'b1;
            default: ;
        endcase
    end

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (wbRegWr && wbDst != '0)
            regs[wbDst] <= wbData;
    end

    // same-cycle writeback is seen by the read
    always_comb begin
        rsVal = (wbRegWr && wbDst == ifIdRs) ? wbData : regs[ifIdRs];
        rtVal = (wbRegWr && wbDst == ifIdRt) ? wbData : regs[ifIdRt];
        if (ifIdRs == '0)
            rsVal = '0;
        if (ifIdRt == '0)
            rtVal = '0;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            {idEx.regWr, idEx.memRd, idEx.memWr, idEx.memToReg, idEx.beq} <= '0;
            {idEx.bne, idEx.jump, idEx.aluSrc, idEx.regDst, idEx.isFin} <= '0;
        end else begin
            idEx.regWr    <= cRegWr && !bubble;
            idEx.memRd    <= cMemRd && !bubble;
            idEx.memWr    <= cMemWr && !bubble;
            idEx.memToReg <= cMemToReg && !bubble;
            idEx.beq      <= cBeq && !bubble;
            idEx.bne      <= cBne && !bubble;
            idEx.jump     <= cJump && !bubble;
            idEx.aluSrc   <= cAluSrc && !bubble;
            idEx.regDst   <= cRegDst && !bubble;
            idEx.isFin    <= cIsFin && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        idEx.funct     <= ifIdInstr[5:0];
        idEx.aluOp     <= cAluOp;
        idEx.rs        <= ifIdRs;
        idEx.rt        <= ifIdRt;
        idEx.rd        <= ifIdInstr[15:11];
        idEx.rsVal     <= rsVal;
        idEx.rtVal     <= rtVal;
        idEx.imm       <= immExt;
        idEx.brTarget  <= ifIdPcNext + {immExt[29:0], 2'b00};
        idEx.jmpTarget <= {ifIdPcNext[31:28], ifIdInstr[25:0], 2'b00};
    end

    // a writeback aimed at register 0 never reaches a read of it
    zeroRegFixed: assert property (@(posedge clk) disable iff (!rstN)
        (wbRegWr && wbDst == '0) |->
            (ifIdRs != '0 || rsVal == '0) && (ifIdRt != '0 || rtVal == '0));

endmodule

// File: fetchStage.sv
// ##########################################################
// fetchStage
// program counter, loadable instruction memory and the
// IF/ID register with hold on stall and bubble on flush
// ##########################################################
module fetchStage (
    input  logic              clk,
    input  logic              rstN,
    input  logic              run,
    input  logic              imemWrEn,
    input  pipePkg::imemIdx_t imemWrAddr,
    input  isaPkg::word_t     imemWrData,
    input  logic              stall,
    input  logic              pcLoad,
    input  isaPkg::word_t     pcTarget,
    output isaPkg::word_t     ifIdInstr,
    output isaPkg::word_t     ifIdPcNext
);
    isaPkg::word_t     pc;
    isaPkg::word_t     pcNext;
    isaPkg::word_t     instr;
    pipePkg::imemIdx_t pcIdx;
    isaPkg::word_t     imem [pipePkg::IMEM_DEPTH];

    assign pcNext = pc + 32'd4;
    assign pcIdx  = pc[9:2];
    assign instr  = imem[pcIdx];

    // load port used while run is low
    always_ff @(posedge clk) begin
        if (imemWrEn)
            imem[imemWrAddr] <= imemWrData;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            pc <= '0;
        else if (pcLoad)
            pc <= pcTarget;
        else if (run && !stall)
            pc <= pcNext;
    end

    // redirect wins over stall, and stall keeps the held instruction even with run low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            ifIdInstr <= isaPkg::NOP_WORD;
        else if (pcLoad || (!run && !stall))
            ifIdInstr <= isaPkg::NOP_WORD;
        else if (!stall)
            ifIdInstr <= instr;
    end

    always_ff @(posedge clk) begin
        if (!stall)
            ifIdPcNext <= pcNext;
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00);

endmodule

// File: pipeIf.sv
// ##########################################################
// idExIf, exMemIf
// pipeline register bundles between decode, execute and
// memory; the hazard unit watches them as a monitor
// ##########################################################
interface idExIf;
    logic regWr, memRd, memWr, memToReg;
    logic beq, bne, jump, aluSrc, regDst, isFin;
    isaPkg::funct_t   funct;
    isaPkg::aluOp_t   aluOp;
    isaPkg::regAddr_t rs, rt, rd;
    isaPkg::word_t    rsVal, rtVal, imm;
    isaPkg::word_t    brTarget, jmpTarget;

    modport producer (output regWr, memRd, memWr, memToReg, beq, bne, jump, aluSrc,
                      regDst, isFin, funct, aluOp, rs, rt, rd, rsVal, rtVal, imm,
                      brTarget, jmpTarget);
    modport consumer (input regWr, memRd, memWr, memToReg, beq, bne, jump, aluSrc,
                      regDst, isFin, funct, aluOp, rs, rt, rd, rsVal, rtVal, imm,
                      brTarget, jmpTarget);
    // load-use detection and forward source matching
    modport monitor (input memRd, rs, rt);
endinterface

interface exMemIf;
    logic regWr, memRd, memWr, memToReg;
    logic beq, bne, jump, isFin;
    logic zero;
    isaPkg::word_t    aluResult, storeData;
    isaPkg::regAddr_t dst;
    isaPkg::word_t    brTarget, jmpTarget;

    modport producer (output regWr, memRd, memWr, memToReg, beq, bne, jump, isFin,
                      zero, aluResult, storeData, dst, brTarget, jmpTarget);
    modport consumer (input regWr, memRd, memWr, memToReg, beq, bne, jump, isFin,
                      zero, aluResult, storeData, dst, brTarget, jmpTarget);
    modport monitor (input regWr, dst);
endinterface

// File: pipePkg.sv
// ##########################################################
// pipePkg
// pipeline organisation: memory sizes, memory word indexes
// and the operand forwarding select codes
// ##########################################################
package pipePkg;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    // word indexes taken from address bits [9:2]
    typedef logic [7:0] imemIdx_t;
    typedef logic [7:0] dmemIdx_t;

    typedef logic [1:0] fwdSel_t;

    // code 3 is never produced
    localparam fwdSel_t FWD_NONE  = 2'd0;
    localparam fwdSel_t FWD_EXMEM = 2'd1;
    localparam fwdSel_t FWD_MEMWB = 2'd2;

endpackage

// File: isaPkg.sv
// ##########################################################
// isaPkg
// instruction-set definitions for the MIPS subset: word and
// field types, opcodes, R-type funct codes, ALU operations
// ##########################################################
package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;
    typedef logic [2:0]  aluOp_t;

    // primary opcodes in instr[31:26]
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2B;
    // end of program marker
    localparam opcode_t OP_FIN   = 6'h3F;

    // R-type funct field in instr[5:0]
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2A;

    localparam aluOp_t ALU_ADD = 3'd0;
    localparam aluOp_t ALU_SUB = 3'd1;
    localparam aluOp_t ALU_AND = 3'd2;
    localparam aluOp_t ALU_OR  = 3'd3;
    localparam aluOp_t ALU_SLT = 3'd4;

    // bubble inserted into IF/ID
    localparam word_t NOP_WORD = 32'h0000_0000;

endpackage
